/* hdl/datapath_macros.svh */
// word width, register count and reset address for the core datapath
`ifndef DATAPATH_MACROS_SVH
`define DATAPATH_MACROS_SVH

// data and address width
`define WORD_W 32

// architectural register count, register 0 reads zero
`define REG_N 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* hdl/isa_pkg.sv */
// opcode and funct3 encodings and the instruction word union
package isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_HALT   = 7'b1111111
    } opcode_t;

    // one code can mean different things under different opcodes
    typedef enum logic [2:0] {
        F3_ADD_EQ = 3'b000,  // add, sub, addi, beq
        F3_NE     = 3'b001,  // bne
        F3_SLT_W  = 3'b010,  // slt, lw, sw
        F3_XOR    = 3'b100,
        F3_OR     = 3'b110,
        F3_AND    = 3'b111
    } funct3_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_t    funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_form_t;

    // addi, lw and jal, all with a signed 12-bit offset
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        funct3_t     funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_form_t;

    // sw; branches reuse it with the bits in branch order
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_t    funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
        s_form_t s_form;
    } instr_u;

endpackage

/* hdl/datapath_pkg.sv */
// ALU and memory access encodings and the pipeline latch structs
`include "datapath_macros.svh"

package datapath_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_type_t;

    // fetch to scoreboard latch
    typedef struct packed {
        logic [`WORD_W-1:0] instr;
        logic [`WORD_W-1:0] pc;
    } fetch_t;

    // execute to writeback latch
    typedef struct packed {
        logic                      done;
        logic [`WORD_W-1:0]        wdat;
        logic [$clog2(`REG_N)-1:0] reg_sel;
    } execute_t;

endpackage

/* hdl/fetch_stage.sv */
// program counter, instruction request and redirect on misprediction
`timescale 1ns/1ps
`include "datapath_macros.svh"

module fetch_stage (
    input  logic               CLK,
    input  logic               nrst,
    input  logic               ihit,
    input  logic [`WORD_W-1:0] imem_load,
    input  logic               freeze,
    input  logic               misprediction,
    input  logic [`WORD_W-1:0] correct_pc,
    input  logic               halt,
    output logic               imem_ren,
    output logic [`WORD_W-1:0] imem_addr,
    output logic [`WORD_W-1:0] instr,
    output logic [`WORD_W-1:0] pc,
    output logic               valid
);
    logic [`WORD_W-1:0] pc_q;
    logic               accept;

    // a hit only counts when the latch can take it and the path is still right
    assign accept = ihit && !freeze && !misprediction && !halt;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc_q <= `RESET_PC;
        end else if (misprediction) begin
            // request in flight is dropped, new address goes out next cycle
            pc_q <= correct_pc;
        end else if (accept) begin
            pc_q <= pc_q + `WORD_W'd4;
        end
    end

    // keeps asking at the same address while frozen
    assign imem_ren  = !halt;
    assign imem_addr = pc_q;

    // word goes straight to the latch in the hit cycle
    assign instr = imem_load;
    assign pc    = pc_q;
    assign valid = accept;

endmodule

/* hdl/scoreboard.sv */
// decode, register file, pending-write tracking, operand read and issue
`timescale 1ns/1ps
`include "datapath_macros.svh"

module scoreboard (
    input  logic                      CLK,
    input  logic                      nrst,
    input  logic [`WORD_W-1:0]        fetch_instr,
    input  logic [`WORD_W-1:0]        fetch_pc,
    input  logic                      fetch_valid,
    input  logic                      ex_busy,
    input  logic                      misprediction,
    input  logic                      reg_en,
    input  logic [$clog2(`REG_N)-1:0] reg_sel,
    input  logic [`WORD_W-1:0]        reg_wdat,
    output logic                      freeze,
    output logic                      iss_en,
    output datapath_pkg::alu_op_t     iss_alu_op,
    output datapath_pkg::mem_type_t   iss_mem_type,
    output logic [1:0]                iss_branch,
    output logic                      iss_jal,
    output logic                      iss_halt,
    output logic [`WORD_W-1:0]        iss_rdat1,
    output logic [`WORD_W-1:0]        iss_rdat2,
    output logic [`WORD_W-1:0]        iss_imm,
    output logic [`WORD_W-1:0]        iss_pc,
    output logic [$clog2(`REG_N)-1:0] iss_rd
);
    localparam int SEL_W = $clog2(`REG_N);

    isa_pkg::instr_u         word;
    logic [`WORD_W-1:0]      regs [`REG_N];
    logic [`REG_N-1:0]       pending;
    logic                    halted;
    logic [SEL_W-1:0]        rs1, rs2, rd;
    logic                    use_rs1, use_rs2, imm_as_rs2;
    datapath_pkg::alu_op_t   alu_op;
    datapath_pkg::mem_type_t mem_type;
    logic [1:0]              branch;
    logic                    jal, halt_op;
    logic [`WORD_W-1:0]      imm, rdat1, rdat2;
    logic                    rs1_busy, rs2_busy, rd_busy, can_issue;

    assign word = fetch_instr;
    assign rs1  = word.r_form.rs1;
    assign rs2  = word.r_form.rs2;

    assign use_rs2 = word.r_form.opcode inside
        {isa_pkg::OPC_OP, isa_pkg::OPC_STORE, isa_pkg::OPC_BRANCH};
    assign use_rs1 = use_rs2 || word.r_form.opcode inside
        {isa_pkg::OPC_OP_IMM, isa_pkg::OPC_LOAD};

    // the opcode picks which view of the word is valid
    always_comb begin
        rd         = '0;
        imm        = {{(`WORD_W-12){word.i_form.imm[11]}}, word.i_form.imm};
        imm_as_rs2 = 1'b0;
        alu_op     = datapath_pkg::ALU_ADD;
        mem_type   = datapath_pkg::MEM_NONE;
        branch     = 2'b00;
        jal        = 1'b0;
        halt_op    = 1'b0;
        case (word.r_form.opcode)
            isa_pkg::OPC_OP: begin
                rd = word.r_form.rd;
                case (word.r_form.funct3)
                    isa_pkg::F3_ADD_EQ: alu_op = word.r_form.funct7[5] ?
                        datapath_pkg::ALU_SUB : datapath_pkg::ALU_ADD;
                    isa_pkg::F3_SLT_W: alu_op = datapath_pkg::ALU_SLT;
                    isa_pkg::F3_XOR:   alu_op = datapath_pkg::ALU_XOR;
                    isa_pkg::F3_OR:    alu_op = datapath_pkg::ALU_OR;
                    isa_pkg::F3_AND:   alu_op = datapath_pkg::ALU_AND;
                    default:           alu_op = datapath_pkg::ALU_ADD;
                endcase
            end
            isa_pkg::OPC_OP_IMM: begin
                rd         = word.i_form.rd;
                imm_as_rs2 = 1'b1;
            end
            isa_pkg::OPC_LOAD: begin
                rd       = word.i_form.rd;
                mem_type = datapath_pkg::MEM_LOAD;
            end
            isa_pkg::OPC_STORE: begin
                mem_type = datapath_pkg::MEM_STORE;
                imm = {{(`WORD_W-12){word.s_form.imm_hi[6]}},
                       word.s_form.imm_hi, word.s_form.imm_lo};
            end
            isa_pkg::OPC_BRANCH: begin
                branch = {1'b1, word.s_form.funct3 == isa_pkg::F3_NE};
                imm = {{(`WORD_W-13){word.s_form.imm_hi[6]}}, word.s_form.imm_hi[6],
                       word.s_form.imm_lo[0], word.s_form.imm_hi[5:0],
                       word.s_form.imm_lo[4:1], 1'b0};
            end
            isa_pkg::OPC_JAL: begin
                rd  = word.i_form.rd;
                jal = 1'b1;
            end
            isa_pkg::OPC_HALT: halt_op = 1'b1;
            default: ;
        endcase
    end

    // register 0 reads zero, a write in this cycle is forwarded
    assign rdat1 = (rs1 == '0) ? '0 : (reg_en && reg_sel == rs1) ? reg_wdat : regs[rs1];
    assign rdat2 = (rs2 == '0) ? '0 : (reg_en && reg_sel == rs2) ? reg_wdat : regs[rs2];

    // a pending bit cleared by writeback this cycle no longer blocks
    assign rs1_busy = use_rs1 && pending[rs1] && !(reg_en && reg_sel == rs1);
    assign rs2_busy = use_rs2 && pending[rs2] && !(reg_en && reg_sel == rs2);
    assign rd_busy  = (rd != '0) && pending[rd] && !(reg_en && reg_sel == rd);

    assign can_issue = fetch_valid && !rs1_busy && !rs2_busy && !rd_busy
                       && !ex_busy && !misprediction && !halted;
    assign freeze    = fetch_valid && !can_issue;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            iss_en  <= 1'b0;
            halted  <= 1'b0;
            pending <= '0;
        end else begin
            iss_en <= can_issue;
            if (can_issue && halt_op) begin
                halted <= 1'b1;
            end
            // set after clear so a new writer of the same register wins
            if (reg_en) begin
                pending[reg_sel] <= 1'b0;
            end
            if (can_issue && rd != '0) begin
                pending[rd] <= 1'b1;
            end
        end
    end

    // issue payload, qualified by iss_en downstream
    always_ff @(posedge CLK) begin
        if (can_issue) begin
            iss_alu_op   <= alu_op;
            iss_mem_type <= mem_type;
            iss_branch   <= branch;
            iss_jal      <= jal;
            iss_halt     <= halt_op;
            iss_rdat1    <= rdat1;
            iss_rdat2    <= imm_as_rs2 ? imm : rdat2;
            iss_imm      <= imm;
            iss_pc       <= fetch_pc;
            iss_rd       <= rd;
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_en && reg_sel != '0) begin
            regs[reg_sel] <= reg_wdat;
        end
    end

endmodule

/* hdl/execute.sv */
// ALU, branch resolution and scalar load/store unit
`timescale 1ns/1ps
`include "datapath_macros.svh"

module execute (
    input  logic                      CLK,
    input  logic                      nrst,
    input  logic                      iss_en,
    input  datapath_pkg::alu_op_t     iss_alu_op,
    input  datapath_pkg::mem_type_t   iss_mem_type,
    input  logic [1:0]                iss_branch,
    input  logic                      iss_jal,
    input  logic                      iss_halt,
    input  logic [`WORD_W-1:0]        iss_rdat1,
    input  logic [`WORD_W-1:0]        iss_rdat2,
    input  logic [`WORD_W-1:0]        iss_imm,
    input  logic [`WORD_W-1:0]        iss_pc,
    input  logic [$clog2(`REG_N)-1:0] iss_rd,
    input  logic                      dhit,
    input  logic [`WORD_W-1:0]        dmem_load,
    output logic                      dmem_ren,
    output logic                      dmem_wen,
    output logic [`WORD_W-1:0]        dmem_addr,
    output logic [`WORD_W-1:0]        dmem_store,
    output logic                      ex_busy,
    output logic                      done,
    output logic [`WORD_W-1:0]        wdat,
    output logic [$clog2(`REG_N)-1:0] rd,
    output logic                      misprediction,
    output logic [`WORD_W-1:0]        correct_pc,
    output logic                      halt
);
    localparam int SEL_W = $clog2(`REG_N);

    logic [`WORD_W-1:0] alu_out;
    logic               taken, mem_issue, alu_done, ls_done;
    logic               ls_active, ls_load, halt_q;
    logic [SEL_W-1:0]   ls_rd;

    always_comb begin
        case (iss_alu_op)
            datapath_pkg::ALU_SUB: alu_out = iss_rdat1 - iss_rdat2;
            datapath_pkg::ALU_AND: alu_out = iss_rdat1 & iss_rdat2;
            datapath_pkg::ALU_OR:  alu_out = iss_rdat1 | iss_rdat2;
            datapath_pkg::ALU_XOR: alu_out = iss_rdat1 ^ iss_rdat2;
            datapath_pkg::ALU_SLT:
                alu_out = {{(`WORD_W-1){1'b0}}, $signed(iss_rdat1) < $signed(iss_rdat2)};
            default:               alu_out = iss_rdat1 + iss_rdat2;
        endcase
    end

    // not-taken is predicted, so every taken branch and every jal redirects
    assign taken = iss_branch[1] &&
                   (iss_branch[0] ? iss_rdat1 != iss_rdat2 : iss_rdat1 == iss_rdat2);
    assign misprediction = iss_en && (taken || iss_jal);
    assign correct_pc    = iss_pc + iss_imm;

    assign mem_issue = iss_en && iss_mem_type != datapath_pkg::MEM_NONE;
    assign alu_done  = iss_en && iss_mem_type == datapath_pkg::MEM_NONE;

    // request goes out the cycle after issue and holds until dhit
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            ls_active <= 1'b0;
        end else if (mem_issue) begin
            ls_active <= 1'b1;
        end else if (dhit) begin
            ls_active <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (mem_issue) begin
            ls_load    <= iss_mem_type == datapath_pkg::MEM_LOAD;
            ls_rd      <= iss_rd;
            dmem_addr  <= iss_rdat1 + iss_imm;
            dmem_store <= iss_rdat2;
        end
    end

    assign dmem_ren = ls_active && ls_load;
    assign dmem_wen = ls_active && !ls_load;
    assign ls_done  = ls_active && dhit;

    // drops in the dhit cycle so the next issue lands right after
    assign ex_busy = mem_issue || (ls_active && !dhit);

    // the two sources never finish in the same cycle
    assign done = alu_done || ls_done;
    always_comb begin
        if (ls_done) begin
            wdat = dmem_load;
            rd   = ls_rd;
        end else begin
            wdat = iss_jal ? iss_pc + `WORD_W'd4 : alu_out;
            rd   = iss_rd;
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            halt_q <= 1'b0;
        end else if (iss_en && iss_halt) begin
            halt_q <= 1'b1;
        end
    end

    assign halt = halt_q || (iss_en && iss_halt);

endmodule

/* hdl/writeback.sv */
// register file write from the execute latch and retire counter
`timescale 1ns/1ps
`include "datapath_macros.svh"

module writeback (
    input  logic                      CLK,
    input  logic                      nrst,
    input  logic                      done,
    input  logic [`WORD_W-1:0]        wdat,
    input  logic [$clog2(`REG_N)-1:0] rd,
    output logic                      reg_en,
    output logic [$clog2(`REG_N)-1:0] reg_sel,
    output logic [`WORD_W-1:0]        reg_wdat
);
    logic [`WORD_W-1:0] retire_cnt;

    // stores, branches and halt retire with rd of zero and write nothing
    assign reg_en   = done && rd != '0;
    assign reg_sel  = rd;
    assign reg_wdat = wdat;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            retire_cnt <= '0;
        end else if (done) begin
            retire_cnt <= retire_cnt + 1'b1;
        end
    end

endmodule

/* hdl/sc_datapath.sv */
// core datapath top with stage instances, pipeline latches and memory ports
`timescale 1ns/1ps
`include "datapath_macros.svh"

module sc_datapath (
    input  logic               CLK,
    input  logic               nrst,
    output logic               imem_ren,
    output logic [`WORD_W-1:0] imem_addr,
    input  logic               ihit,
    input  logic [`WORD_W-1:0] imem_load,
    output logic               dmem_ren,
    output logic               dmem_wen,
    output logic [`WORD_W-1:0] dmem_addr,
    output logic [`WORD_W-1:0] dmem_store,
    input  logic               dhit,
    input  logic [`WORD_W-1:0] dmem_load,
    output logic               halt
);
    datapath_pkg::fetch_t    fetch_out, sb_in;
    datapath_pkg::execute_t  ex_out, wb_in;
    logic                    f_valid, sb_valid;
    logic                    freeze, misprediction, ex_busy;
    logic [`WORD_W-1:0]      correct_pc;

    // issue bundle
    logic                          iss_en, iss_jal, iss_halt;
    datapath_pkg::alu_op_t         iss_alu_op;
    datapath_pkg::mem_type_t       iss_mem_type;
    logic [1:0]                    iss_branch;
    logic [`WORD_W-1:0]            iss_rdat1, iss_rdat2, iss_imm, iss_pc;
    logic [$clog2(`REG_N)-1:0]     iss_rd;

    // register file write
    logic                          reg_en;
    logic [$clog2(`REG_N)-1:0]     reg_sel;
    logic [`WORD_W-1:0]            reg_wdat;

    fetch_stage u_fetch (
        .CLK(CLK), .nrst(nrst), .ihit(ihit), .imem_load(imem_load),
        .freeze(freeze), .misprediction(misprediction), .correct_pc(correct_pc),
        .halt(halt), .imem_ren(imem_ren), .imem_addr(imem_addr),
        .instr(fetch_out.instr), .pc(fetch_out.pc), .valid(f_valid)
    );

    scoreboard u_scoreboard (
        .CLK(CLK), .nrst(nrst), .fetch_instr(sb_in.instr), .fetch_pc(sb_in.pc),
        .fetch_valid(sb_valid), .ex_busy(ex_busy), .misprediction(misprediction),
        .reg_en(reg_en), .reg_sel(reg_sel), .reg_wdat(reg_wdat), .freeze(freeze),
        .iss_en(iss_en), .iss_alu_op(iss_alu_op), .iss_mem_type(iss_mem_type),
        .iss_branch(iss_branch), .iss_jal(iss_jal), .iss_halt(iss_halt),
        .iss_rdat1(iss_rdat1), .iss_rdat2(iss_rdat2), .iss_imm(iss_imm),
        .iss_pc(iss_pc), .iss_rd(iss_rd)
    );

    execute u_execute (
        .CLK(CLK), .nrst(nrst), .iss_en(iss_en), .iss_alu_op(iss_alu_op),
        .iss_mem_type(iss_mem_type), .iss_branch(iss_branch), .iss_jal(iss_jal),
        .iss_halt(iss_halt), .iss_rdat1(iss_rdat1), .iss_rdat2(iss_rdat2),
        .iss_imm(iss_imm), .iss_pc(iss_pc), .iss_rd(iss_rd), .dhit(dhit),
        .dmem_load(dmem_load), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
        .dmem_addr(dmem_addr), .dmem_store(dmem_store), .ex_busy(ex_busy),
        .done(ex_out.done), .wdat(ex_out.wdat), .rd(ex_out.reg_sel),
        .misprediction(misprediction), .correct_pc(correct_pc), .halt(halt)
    );

    writeback u_writeback (
        .CLK(CLK), .nrst(nrst), .done(wb_in.done), .wdat(wb_in.wdat),
        .rd(wb_in.reg_sel), .reg_en(reg_en), .reg_sel(reg_sel), .reg_wdat(reg_wdat)
    );

    // fetch latch holds on freeze, drops the wrong-path word on misprediction
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            sb_in    <= '0;
            sb_valid <= 1'b0;
            wb_in    <= '0;
        end else begin
            if (misprediction) begin
                sb_valid <= 1'b0;
            end else if (!freeze) begin
                sb_in    <= fetch_out;
                sb_valid <= f_valid;
            end
            wb_in <= ex_out;
        end
    end

endmodule

/* sim/clock_gen.sv */
// clock and reset source for the datapath testbench
`timescale 1ns/1ps

module clock_gen (
    output logic CLK,
    output logic nrst
);
    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // three rising edges in reset, released on a falling edge
    initial begin
        nrst = 1'b0;
        repeat (3) @(negedge CLK);
        nrst = 1'b1;
    end

endmodule

/* sim/datapath_properties.sv */
// concurrent checks on the data-memory handshake and the quiet data port after halt
`timescale 1ns/1ps
`include "datapath_macros.svh"

module datapath_properties (
    input logic               CLK,
    input logic               nrst,
    input logic               dmem_ren,
    input logic               dmem_wen,
    input logic [`WORD_W-1:0] dmem_addr,
    input logic [`WORD_W-1:0] dmem_store,
    input logic               dhit,
    input logic               halt
);
    // a request waiting for dhit must not move
    a_req_stable: assert property (@(posedge CLK) disable iff (!nrst)
        (dmem_ren || dmem_wen) && !dhit |=>
            $stable({dmem_ren, dmem_wen, dmem_addr, dmem_store}))
        else $error("data request changed while waiting for dhit");

    // one hit ends the request
    a_hit_completes: assert property (@(posedge CLK) disable iff (!nrst)
        dhit |=> !dmem_ren && !dmem_wen)
        else $error("data request still raised after its dhit");

    // no data access once halted
    a_halt_quiet: assert property (@(posedge CLK) disable iff (!nrst)
        halt |-> !dmem_ren && !dmem_wen)
        else $error("data request while halted");

endmodule

/* sim/datapath_tb.sv */
// testbench with random program, memory models, ISA reference model and checks
`timescale 1ns/1ps
`include "datapath_macros.svh"

module datapath_tb;
    localparam int PROG_N = 64;
    localparam int BODY_N = 56;
    localparam int LIMIT  = 40 * PROG_N;

    logic               CLK, nrst, halt;
    logic               imem_ren, ihit, dmem_ren, dmem_wen, dhit;
    logic [`WORD_W-1:0] imem_addr, imem_load, dmem_addr, dmem_store, dmem_load;

    logic [`WORD_W-1:0] prog [PROG_N];
    logic [`WORD_W-1:0] dmem [256];
    logic [`WORD_W-1:0] mdat [256];
    logic [`WORD_W-1:0] exp_addr [$];
    logic [`WORD_W-1:0] exp_data [$];
    int seed = 55;
    int iwait = 0;
    int dwait = 0;
    int n_store = 0;
    int exp_retired = 0;
    int errors = 0;
    int tests = 0;
    int bad_tests = 0;
    int cycles, err_mark;

    clock_gen u_clock_gen (.CLK(CLK), .nrst(nrst));

    sc_datapath u_sc_datapath (
        .CLK(CLK), .nrst(nrst), .imem_ren(imem_ren), .imem_addr(imem_addr),
        .ihit(ihit), .imem_load(imem_load), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
        .dmem_addr(dmem_addr), .dmem_store(dmem_store), .dhit(dhit),
        .dmem_load(dmem_load), .halt(halt)
    );

    bind sc_datapath datapath_properties u_properties (
        .CLK(CLK), .nrst(nrst), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
        .dmem_addr(dmem_addr), .dmem_store(dmem_store), .dhit(dhit), .halt(halt)
    );

    // preload pattern hashed from the byte address so signs vary
    function automatic logic [`WORD_W-1:0] fill_word(input logic [`WORD_W-1:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'hC3A5_1E0F;
    endfunction

    // past the program end the memory returns halt
    function automatic logic [`WORD_W-1:0] fetch_word(input logic [`WORD_W-1:0] addr);
        if (addr < 4 * PROG_N) begin
            return prog[addr[7:2]];
        end
        return {25'd0, isa_pkg::OPC_HALT};
    endfunction

    function automatic logic [4:0] rnd_reg();
        return 5'(1 + {$random(seed)} % 7);
    endfunction

    // op codes 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt
    function automatic logic [`WORD_W-1:0] r_word(input int op, input logic [4:0] rd, rs1, rs2);
        logic [2:0] f3;
        case (op)
            2: f3 = 3'b111;
            3: f3 = 3'b110;
            4: f3 = 3'b100;
            5: f3 = 3'b010;
            default: f3 = 3'b000;
        endcase
        return {(op == 1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, isa_pkg::OPC_OP};
    endfunction

    function automatic logic [`WORD_W-1:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                 input logic [2:0] f3, input logic [4:0] rd,
                                                 input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [`WORD_W-1:0] s_word(input logic [4:0] rs2, input logic [11:0] off);
        return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], isa_pkg::OPC_STORE};
    endfunction

    function automatic logic [`WORD_W-1:0] b_word(input logic ne, input logic [4:0] rs1, rs2,
                                                 input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], isa_pkg::OPC_BRANCH};
    endfunction

    task automatic compare_word(input string name, input logic [`WORD_W-1:0] expected,
                                input logic [`WORD_W-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int mark);
        tests++;
        if (errors > mark) begin
            bad_tests++;
            $display("%-20s FAIL", name);
        end else begin
            $display("%-20s ok", name);
        end
    endtask

    task automatic check_store(input logic [`WORD_W-1:0] addr, input logic [`WORD_W-1:0] data);
        string name;
        int mark;
        name = $sformatf("store%0d", n_store);
        mark = errors;
        if (n_store < exp_addr.size()) begin
            compare_word({name, "_addr"}, exp_addr[n_store], addr);
            compare_word({name, "_data"}, exp_data[n_store], data);
        end else begin
            $display("store to %h is beyond the %0d stores expected", addr, exp_addr.size());
            errors++;
        end
        n_store++;
        end_test(name, mark);
    endtask

    // body of random ops with forward skips, then stores of x1..x7 and halt
    task automatic build_program();
        int kind, skip, jal_at;
        jal_at = 8 + {$random(seed)} % 40;
        for (int i = 0; i < BODY_N; i++) begin
            kind = {$random(seed)} % 16;
            skip = 1 + {$random(seed)} % 3;
            if (i == jal_at) begin
                prog[i] = i_word(12'(4 * (skip + 1)), 5'd0, 3'b000, rnd_reg(), isa_pkg::OPC_JAL);
            end else if (kind >= 14 && i + skip < BODY_N) begin
                prog[i] = b_word(kind == 15, rnd_reg(), rnd_reg(), 13'(4 * (skip + 1)));
            end else if (kind == 13) begin
                prog[i] = s_word(rnd_reg(), 12'(12'h280 + 4 * ({$random(seed)} % 8)));
            end else if (kind >= 11) begin
                prog[i] = i_word(12'(12'h100 + 4 * ({$random(seed)} % 16)), 5'd0, 3'b010,
                                 rnd_reg(), isa_pkg::OPC_LOAD);
            end else if (kind >= 8) begin
                prog[i] = i_word(12'($random(seed)), rnd_reg(), 3'b000, rnd_reg(),
                                 isa_pkg::OPC_OP_IMM);
            end else begin
                prog[i] = r_word(kind % 6, rnd_reg(), rnd_reg(), rnd_reg());
            end
        end
        for (int k = 1; k < 8; k++) begin
            prog[BODY_N + k - 1] = s_word(5'(k), 12'(12'h200 + 4 * k));
        end
        prog[PROG_N - 1] = {25'd0, isa_pkg::OPC_HALT};
    endtask

    // instruction-level model that fills the expected store list
    task automatic run_model();
        logic [`WORD_W-1:0] r [32];
        logic [`WORD_W-1:0] pc, nxt, w, a, b, addr, imm_i, imm_s, imm_b;
        int steps;
        for (int k = 0; k < 32; k++) begin
            r[k] = '0;
        end
        pc    = `RESET_PC;
        w     = fetch_word(pc);
        steps = 0;
        while (w[6:0] != isa_pkg::OPC_HALT && steps < 4 * PROG_N) begin
            a     = r[w[19:15]];
            b     = r[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            nxt   = pc + 4;
            case (w[6:0])
                isa_pkg::OPC_OP: begin
                    case (w[14:12])
                        3'b000: r[w[11:7]] = w[30] ? a - b : a + b;
                        3'b111: r[w[11:7]] = a & b;
                        3'b110: r[w[11:7]] = a | b;
                        3'b100: r[w[11:7]] = a ^ b;
                        default: r[w[11:7]] = {31'd0, $signed(a) < $signed(b)};
                    endcase
                end
                isa_pkg::OPC_OP_IMM: r[w[11:7]] = a + imm_i;
                isa_pkg::OPC_LOAD: begin
                    addr = a + imm_i;
                    r[w[11:7]] = mdat[addr[9:2]];
                end
                isa_pkg::OPC_STORE: begin
                    addr = a + imm_s;
                    mdat[addr[9:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                isa_pkg::OPC_BRANCH: begin
                    if (w[12] ? a != b : a == b) begin
                        nxt = pc + imm_b;
                    end
                end
                isa_pkg::OPC_JAL: begin
                    r[w[11:7]] = pc + 4;
                    nxt = pc + imm_i;
                end
                default: ;
            endcase
            r[0]  = '0;
            pc    = nxt;
            w     = fetch_word(pc);
            steps++;
        end
        // halt retires too
        exp_retired = steps + 1;
    endtask

    // instruction memory with 0 to 3 wait cycles per hit
    always @(negedge CLK) begin
        ihit <= 1'b0;
        if (imem_ren) begin
            if (iwait == 0) begin
                ihit      <= 1'b1;
                imem_load <= fetch_word(imem_addr);
                iwait     <= {$random(seed)} % 4;
            end else begin
                iwait <= iwait - 1;
            end
        end
    end

    // data memory that checks each store as it completes
    always @(negedge CLK) begin
        dhit <= 1'b0;
        if (dmem_ren || dmem_wen) begin
            if (dwait == 0) begin
                dhit  <= 1'b1;
                dwait <= {$random(seed)} % 4;
                if (dmem_wen) begin
                    dmem[dmem_addr[9:2]] <= dmem_store;
                    check_store(dmem_addr, dmem_store);
                end else begin
                    dmem_load <= dmem[dmem_addr[9:2]];
                end
            end else begin
                dwait <= dwait - 1;
            end
        end
    end

    initial begin
        ihit      = 1'b0;
        imem_load = '0;
        dhit      = 1'b0;
        dmem_load = '0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(i * 4);
            mdat[i] = dmem[i];
        end
        build_program();
        run_model();

        @(posedge nrst);
        cycles = 0;
        while (!halt && cycles < LIMIT) begin
            @(negedge CLK);
            cycles++;
        end

        if (!halt) begin
            $display("timeout: halt did not rise within %0d cycles", LIMIT);
            errors++;
        end else begin
            // every store must be done by the time halt rises
            err_mark = errors;
            compare_word("store_count", exp_addr.size(), n_store);
            end_test("store_count", err_mark);
            err_mark = errors;
            repeat (4) @(negedge CLK);
            compare_flag("halt_held", 1'b1, halt);
            compare_word("stores_after_halt", exp_addr.size(), n_store);
            end_test("halt_held", err_mark);
            err_mark = errors;
            compare_word("retire_count", exp_retired, u_sc_datapath.u_writeback.retire_cnt);
            end_test("retire_count", err_mark);
        end

        $display("tests run %0d, tests failing %0d, check errors %0d", tests, bad_tests, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/datapath_pkg.sv
hdl/fetch_stage.sv
hdl/scoreboard.sv
hdl/execute.sv
hdl/writeback.sv
hdl/sc_datapath.sv
sim/clock_gen.sv
sim/datapath_properties.sv
sim/datapath_tb.sv

/* Bender.yml */
package:
  name: sc_datapath

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/isa_pkg.sv
      - hdl/datapath_pkg.sv
      - hdl/fetch_stage.sv
      - hdl/scoreboard.sv
      - hdl/execute.sv
      - hdl/writeback.sv
      - hdl/sc_datapath.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/clock_gen.sv
      - sim/datapath_properties.sv
      - sim/datapath_tb.sv
